//--- csa_calc_top.f
+incdir+bench
hdl/csa_calc_pkg.sv
hdl/csa_round.sv
hdl/csa_ring_pipe.sv
hdl/csa_loop_ctrl.sv
hdl/csa_calc_top.sv
bench/csa_calc_tb.sv

//--- Bender.yml
package:
  name: csa_calc

sources:
  - files:
      - hdl/csa_calc_pkg.sv
      - hdl/csa_round.sv
      - hdl/csa_ring_pipe.sv
      - hdl/csa_loop_ctrl.sv
      - hdl/csa_calc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/csa_calc_tb.sv

//--- bench/csa_calc_cases.svh
`ifndef CSA_CALC_CASES_SVH
`define CSA_CALC_CASES_SVH

// columns: block tag, key seed, total count, start count, expected passes
// a pass count of 0 marks a job that must leave without a result
typedef struct packed {
	logic [31:0] block;
	logic [39:0] seed;
	logic [31:0] times;
	logic [31:0] times_start;
	int          passes;
} case_row_t;

localparam int NUM_CASES = 12;
localparam int NUM_SOLO  = 3; // first rows run one at a time

string case_name [NUM_CASES] = '{
	"one_pass_diff", "one_pass_equal", "five_pass",
	"zero_total", "zero_total_start", "burst_three",
	"burst_two", "burst_eight", "burst_one",
	"burst_four", "burst_equal", "seed_all_ones"
};

case_row_t case_table [NUM_CASES] = '{
	'{32'h0000_0101, 40'h12_3456_789a, 32'd10,  32'd9,   1},
	'{32'h0000_0102, 40'hff_0000_0001, 32'd7,   32'd7,   1},
	'{32'h0000_0103, 40'h0a_bcde_f012, 32'd105, 32'd100, 5},
	'{32'h0000_0104, 40'h55_aa55_aa55, 32'd0,   32'd0,   0},
	'{32'h0000_0105, 40'h01_0203_0405, 32'd0,   32'd3,   0}, // dropped after its first pass
	'{32'h0000_0106, 40'h00_0000_0000, 32'd3,   32'd0,   3},
	'{32'h0000_0107, 40'h3c_3c3c_3c3c, 32'd8,   32'd6,   2},
	'{32'h0000_0108, 40'h80_0000_0000, 32'd9,   32'd1,   8},
	'{32'h0000_0109, 40'h7f_edcb_a987, 32'd1,   32'd0,   1},
	'{32'h0000_010a, 40'h00_dead_beef, 32'd12,  32'd8,   4},
	'{32'h0000_010b, 40'h19_2837_4655, 32'd5,   32'd5,   1},
	'{32'h0000_010c, 40'hff_ffff_ffff, 32'd3,   32'd1,   2}
};

`endif

//--- bench/csa_calc_tb.sv
`timescale 1ns/1ps

module csa_calc_tb
	import csa_calc_pkg::*;
();

	localparam int PIPE_DEPTH     = 23;
	localparam int CLK_PERIOD     = 20;
	localparam int DRIVE_DELAY    = 1;
	localparam int NUM_RANDOM     = 24;
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [63:0] ROUND_KEY = 64'hE613DB6DC11C4524;

	`include "csa_calc_cases.svh"

	logic        clk;
	logic        rst_n;
	csa_job_in_t job_i;
	logic        job_valid_i;
	logic        job_ren_o;
	csa_result_t result_o;
	logic        result_valid_o;

	csa_job_in_t fifo_q [$]; // show-ahead FIFO model
	logic        pop_req;
	int          cycle_count = 0;
	int          results_seen = 0;
	int          results_expected = 0;

	// scoreboard keyed by block tag
	csa_result_t exp_res [word_t];
	string       exp_name [word_t];
	int          exp_lat [word_t];
	int          accept_cycle [word_t];

	csa_calc_top #(
		.PIPE_DEPTH (PIPE_DEPTH)
	) csa_calc_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.job_i          (job_i),
		.job_valid_i    (job_valid_i),
		.job_ren_o      (job_ren_o),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [255:0] expected,
			input logic [255:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("** Error: %s expected %0h actual %0h", name, expected, actual));
		end
	endtask

	// round model iterated from the zero-extended seed
	function automatic logic [63:0] expected_cipher(input logic [39:0] seed, input int passes);
		logic [63:0] s;
		logic [63:0] k;
		logic [63:0] r;
		logic [63:0] a;
		s = {24'h0, seed};
		for (int i = 0; i < passes; i++) begin
			k = s ^ ROUND_KEY;
			r = {k[50:0], k[63:51]};
			a = r + {24'h0, seed};
			s = a ^ (a >> 7);
		end
		return s;
	endfunction

	function automatic int expected_passes(input word_t times, input word_t start);
		word_t diff;
		diff = times - start;
		if (times == '0) begin
			return 0; // no result at all
		end else if (diff == '0) begin
			return 1;
		end else begin
			return int'(diff);
		end
	endfunction

	task automatic push_job(input string name, input word_t block, input seed_t seed,
			input word_t times, input word_t start, input int passes);
		csa_job_in_t job;
		csa_result_t res;
		job.block       = block;
		job.seed        = seed;
		job.times       = times;
		job.times_start = start;
		fifo_q.push_back(job);
		if (passes > 0) begin
			res.block          = block;
			res.seed           = seed;
			res.times          = times;
			res.times_start    = start;
			res.out            = expected_cipher(seed, passes);
			exp_res[block]     = res;
			exp_name[block]    = name;
			exp_lat[block]     = passes * PIPE_DEPTH + 1;
			results_expected++;
		end
	endtask

	task automatic handle_result();
		word_t tag;
		tag = result_o.block;
		if (!exp_res.exists(tag)) begin
			fail_run($sformatf("result with tag %h arrived but no such job is pending", tag));
		end else begin
			check_value({exp_name[tag], " result"}, exp_res[tag], result_o);
			check_value({exp_name[tag], " latency"}, exp_lat[tag],
				cycle_count - accept_cycle[tag]);
			exp_res.delete(tag);
			results_seen++;
		end
	endtask

	task automatic wait_idle(input string phase);
		int waited;
		waited = 0;
		while ((fifo_q.size() != 0 || exp_res.num() != 0) && waited < TIMEOUT_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (fifo_q.size() != 0 || exp_res.num() != 0) begin
			fail_run($sformatf("timeout: %s jobs were not all accepted and finished", phase));
		end
	endtask

	// FIFO head driven just after the edge
	always @(posedge clk) begin
		#DRIVE_DELAY;
		if (pop_req) begin
			fifo_q.delete(0);
			pop_req = 1'b0;
		end
		if (fifo_q.size() != 0) begin
			job_i       = fifo_q[0];
			job_valid_i = 1'b1;
		end else begin
			job_i       = '0;
			job_valid_i = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (job_ren_o) begin
			if (!job_valid_i) begin
				fail_run("job_ren_o went high while the job FIFO was empty");
			end else begin
				accept_cycle[job_i.block] = cycle_count;
				pop_req = 1'b1;
			end
		end
		if (result_valid_o) handle_result();
	end

	initial begin : main_seq
		word_t r_start;
		word_t r_times;
		seed_t r_seed;

		rst_n       = 1'b0;
		job_i       = '0;
		job_valid_i = 1'b0;
		pop_req     = 1'b0;
		void'($urandom(32'hcece6955));

		repeat (4) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// idle after reset with nothing presented
		repeat (4) begin
			@(negedge clk);
			check_value("reset job_ren_o", 1'b0, job_ren_o);
			check_value("reset result_valid_o", 1'b0, result_valid_o);
			check_value("reset result_o", '0, result_o);
		end

		// single and five-pass jobs alone
		for (int i = 0; i < NUM_SOLO; i++) begin
			@(negedge clk);
			push_job(case_name[i], case_table[i].block, case_table[i].seed,
				case_table[i].times, case_table[i].times_start, case_table[i].passes);
			wait_idle(case_name[i]);
		end

		// rest of the table as one burst
		@(negedge clk);
		for (int i = NUM_SOLO; i < NUM_CASES; i++) begin
			push_job(case_name[i], case_table[i].block, case_table[i].seed,
				case_table[i].times, case_table[i].times_start, case_table[i].passes);
		end

		// more than a ring of jobs, so the tail waits on recirculating slots
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r_seed[39:32] = 8'($urandom());
			r_seed[31:0]  = $urandom();
			r_start       = $urandom() & 32'h00ff_ffff;
			r_times       = r_start + ($urandom() % 7);
			push_job($sformatf("random_%0d", i), 32'h8000_0000 + i, r_seed, r_times,
				r_start, expected_passes(r_times, r_start));
		end
		wait_idle("table burst and random");

		// zero-count jobs must stay silent
		repeat (2 * PIPE_DEPTH) @(negedge clk);
		check_value("result count", results_expected, results_seen);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- hdl/csa_calc_top.sv
`timescale 1ns/1ps

module csa_calc_top
	import csa_calc_pkg::*;
#(
	parameter int PIPE_DEPTH = 23 // ring length, 2 or more
) (
	input  logic        clk,
	input  logic        rst_n,

	// show-ahead job FIFO
	input  csa_job_in_t job_i,
	input  logic        job_valid_i,
	output logic        job_ren_o,

	// results, no back-pressure
	output csa_result_t result_o,
	output logic        result_valid_o
);

	csa_job_t entry_job; // controller -> stage 0
	csa_job_t exit_job;  // last stage -> controller

	csa_loop_ctrl csa_loop_ctrl_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.job_i          (job_i),
		.job_valid_i    (job_valid_i),
		.job_ren_o      (job_ren_o),
		.exit_i         (exit_job),
		.entry_o        (entry_job),
		.result_o       (result_o),
		.result_valid_o (result_valid_o)
	);

	csa_ring_pipe #(
		.PIPE_DEPTH (PIPE_DEPTH)
	) csa_ring_pipe_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.entry_i (entry_job),
		.exit_o  (exit_job)
	);

endmodule

//--- hdl/csa_loop_ctrl.sv
`timescale 1ns/1ps

module csa_loop_ctrl
	import csa_calc_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  csa_job_in_t job_i,
	input  logic        job_valid_i,
	output logic        job_ren_o,

	input  csa_job_t    exit_i,
	output csa_job_t    entry_o,

	output csa_result_t result_o,
	output logic        result_valid_o
);

	// who owns stage 0 this cycle
	typedef enum logic [1:0] {
		SRC_EMPTY,
		SRC_LOOP,
		SRC_FIFO
	} slot_src_e;

	slot_src_e   slot_src;
	logic        exit_live;
	logic        recirc;
	logic        retire;
	csa_job_t    new_job;
	csa_job_t    loop_job;
	csa_result_t result_d;

	// difference of zero still runs once
	function automatic word_t pass_count(input word_t times, input word_t times_start);
		word_t diff;
		diff = times - times_start;
		return (diff == '0) ? word_t'(1) : diff;
	endfunction

	// a zero total count drops out after its first pass
	assign exit_live = exit_i.valid && (exit_i.times != '0);

	assign recirc = exit_live && (exit_i.passes_left > word_t'(1));
	assign retire = exit_live && (exit_i.passes_left == word_t'(1));

	// entry arbitration, recirculating job first
	always_comb begin
		if (recirc) begin
			slot_src = SRC_LOOP;
		end else if (job_valid_i) begin
			slot_src = SRC_FIFO;
		end else begin
			slot_src = SRC_EMPTY;
		end
	end

	// pop the FIFO head only when it actually takes the slot
	assign job_ren_o = (slot_src == SRC_FIFO);

	always_comb begin
		new_job             = '0;
		new_job.valid       = 1'b1;
		new_job.block       = job_i.block;
		new_job.seed        = job_i.seed;
		new_job.times       = job_i.times;
		new_job.times_start = job_i.times_start;
		new_job.passes_left = pass_count(job_i.times, job_i.times_start);
		new_job.state       = cipher_t'(job_i.seed); // round input starts from the seed
	end

	always_comb begin
		loop_job             = exit_i;
		loop_job.passes_left = exit_i.passes_left - word_t'(1);
	end

	always_comb begin
		case (slot_src)
			SRC_LOOP: entry_o = loop_job;
			SRC_FIFO: entry_o = new_job;
			default:  entry_o = '0; // bubble
		endcase
	end

	always_comb begin
		result_d.block       = exit_i.block;
		result_d.seed        = exit_i.seed;
		result_d.times       = exit_i.times;
		result_d.times_start = exit_i.times_start;
		result_d.out         = exit_i.state;
	end

	// registered result port, one pulse per finished job
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result_valid_o <= 1'b0;
			result_o       <= '0;
		end else begin
			result_valid_o <= retire;
			if (retire) begin
				result_o <= result_d;
			end
		end
	end

endmodule

//--- hdl/csa_ring_pipe.sv
`timescale 1ns/1ps

module csa_ring_pipe
	import csa_calc_pkg::*;
#(
	parameter int PIPE_DEPTH = 23
) (
	input  logic     clk,
	input  logic     rst_n,
	input  csa_job_t entry_i,
	output csa_job_t exit_o
);

	// slot[0] is the entry stage, slot[PIPE_DEPTH-1] feeds back to the controller
	csa_job_t slot [PIPE_DEPTH];

	cipher_t  round_out;
	csa_job_t stage1_job;

	csa_round csa_round_inst (
		.state_i (slot[0].state),
		.seed_i  (slot[0].seed),
		.state_o (round_out)
	);

	// one round per pass, applied between stage 0 and stage 1
	always_comb begin
		stage1_job = slot[0];
		if (slot[0].valid) begin
			stage1_job.state = round_out;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				slot[i] <= '0;
			end
		end else begin
			slot[0] <= entry_i;
			slot[1] <= stage1_job;
			// plain shift for the rest of the ring
			for (int i = 2; i < PIPE_DEPTH; i++) begin
				slot[i] <= slot[i-1];
			end
		end
	end

	assign exit_o = slot[PIPE_DEPTH-1];

endmodule

//--- hdl/csa_round.sv
`timescale 1ns/1ps

module csa_round
	import csa_calc_pkg::*;
(
	input  cipher_t state_i,
	input  seed_t   seed_i,
	output cipher_t state_o
);

	cipher_t keyed;
	cipher_t rotated;
	cipher_t seed_ext;
	cipher_t summed;

	// mix in the fixed key
	assign keyed = state_i ^ SB_CONST;

	assign rotated = (keyed << ROT_AMOUNT) | (keyed >> (CIPHER_W - ROT_AMOUNT));

	// seed is zero-extended before the add
	assign seed_ext = cipher_t'(seed_i);

	assign summed = rotated + seed_ext; // wraps mod 2^64

	// fold high bits down into the low ones
	assign state_o = summed ^ (summed >> SHR_AMOUNT);

endmodule

//--- hdl/csa_calc_pkg.sv
package csa_calc_pkg;

	// field widths
	localparam int WORD_W   = 32;
	localparam int SEED_W   = 40;
	localparam int CIPHER_W = 64;

	typedef logic [WORD_W-1:0]   word_t;   // block tag and counts
	typedef logic [SEED_W-1:0]   seed_t;   // key-seed word
	typedef logic [CIPHER_W-1:0] cipher_t; // cipher state and result

	// fixed round key
	localparam cipher_t SB_CONST = 64'hE613_DB6D_C11C_4524;

	localparam int ROT_AMOUNT = 13; // left rotate
	localparam int SHR_AMOUNT = 7;  // right shift for the final mix

	// one ring slot
	typedef struct packed {
		logic    valid;
		word_t   block;
		seed_t   seed;
		word_t   times;
		word_t   times_start;
		word_t   passes_left; // passes still to run, including the current one
		cipher_t state;
	} csa_job_t;

	// finished job
	typedef struct packed {
		word_t   block;
		seed_t   seed;
		word_t   times;
		word_t   times_start;
		cipher_t out;
	} csa_result_t;

	// job as it sits at the head of the input FIFO
	typedef struct packed {
		word_t block;
		seed_t seed;
		word_t times;
		word_t times_start;
	} csa_job_in_t;

endpackage
